/* source/board_defines.svh */
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

////////////////////////////////////////
// board geometry
////////////////////////////////////////

`define BOARD_SIDE 16          // tiles per side
`define TILE_PIXELS 10         // pixels per tile side
`define TILE_COUNT 256

// plotter coordinate widths
`define X_WIDTH 10
`define Y_WIDTH 9

////////////////////////////////////////
// colour codes, rgb
////////////////////////////////////////

`define COLOUR_EMPTY 3'b000
`define COLOUR_RED 3'b100
`define COLOUR_BLUE 3'b001
`define COLOUR_BOTH 3'b111     // both players on one tile

`endif

/* source/boardPkg.sv */
`include "board_defines.svh"

package boardPkg;

    typedef logic [2:0] colour_t;  // rgb, one bit each

    // row or column of a tile
    typedef logic [$clog2(`BOARD_SIDE)-1:0] tileCoord_t;

    typedef struct packed {
        tileCoord_t row;           // upper half
        tileCoord_t column;        // lower half
    } tileField_t;

    // flat index for counting and memory, or split into row and column
    typedef union packed {
        logic [$clog2(`TILE_COUNT)-1:0] index;
        tileField_t field;
    } tileAddress_u;

    typedef logic [`X_WIDTH-1:0] pixelX_t;
    typedef logic [`Y_WIDTH-1:0] pixelY_t;

endpackage

/* source/renderPkg.sv */
package renderPkg;

    // controller states
    typedef enum logic [2:0] {
        Clear,       // post-reset sweep of the board
        Idle,
        WriteRed,
        WriteBlue,
        Scan         // scanner owns the plotter
    } renderState_t;

endpackage

/* source/tileMemory.sv */
`include "board_defines.svh"

module tileMemory
    import boardPkg::*;
(
    input  logic         clock,
    input  logic         writeEnable,
    input  tileAddress_u writeAddress,
    input  colour_t      writeColour,
    input  tileAddress_u readAddress,
    output colour_t      tileColour
);

    // one colour per tile
    colour_t board [`TILE_COUNT];

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (writeEnable) begin
            board[writeAddress.index] <= writeColour;
        end
    end

    ////////////////////////////////////////
    // read port, one cycle latency
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        tileColour <= board[readAddress.index];
    end

endmodule

/* source/tileScanner.sv */
`include "board_defines.svh"

module tileScanner
    import boardPkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         scanStart,
    output tileAddress_u readAddress,
    input  colour_t      tileColour,
    output pixelX_t      x,
    output pixelY_t      y,
    output colour_t      colour,
    output logic         plotEnable,
    output logic         scanDone
);

    // offset of a pixel inside its tile
    typedef logic [$clog2(`TILE_PIXELS)-1:0] offset_t;

    localparam offset_t lastOffset = offset_t'(`TILE_PIXELS - 1);

    logic         active;      // pass in progress
    logic         fetch;       // memory read cycle, nothing plotted
    tileAddress_u tile;
    offset_t      dx;
    offset_t      dy;
    logic         lastTile;

    assign lastTile = tile.index == 8'(`TILE_COUNT - 1);

    ////////////////////////////////////////
    // tile and pixel counters
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            active   <= 1'b0;
            fetch    <= 1'b0;
            tile     <= '0;
            dx       <= '0;
            dy       <= '0;
            scanDone <= 1'b0;
        end else begin
            scanDone <= 1'b0;
            if (scanStart) begin
                active     <= 1'b1;
                fetch      <= 1'b1;
                tile.index <= '0;
                dx         <= '0;
                dy         <= '0;
            end else if (active) begin
                if (fetch) begin
                    fetch <= 1'b0;      // colour arrives now
                end else if (dx == lastOffset) begin
                    dx <= '0;
                    if (dy == lastOffset) begin
                        dy <= '0;
                        if (lastTile) begin
                            active   <= 1'b0;
                            scanDone <= 1'b1;
                        end else begin
                            tile.index <= tile.index + 1'b1;
                            fetch      <= 1'b1;
                        end
                    end else begin
                        dy <= dy + 1'b1;
                    end
                end else begin
                    dx <= dx + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // plotter outputs
    ////////////////////////////////////////

    assign readAddress = tile;   // held for the whole tile
    assign plotEnable  = active && !fetch;
    assign colour      = tileColour;

    // tile origin from the row and column fields
    assign x = pixelX_t'(tile.field.column) * pixelX_t'(`TILE_PIXELS) + pixelX_t'(dx);
    assign y = pixelY_t'(tile.field.row) * pixelY_t'(`TILE_PIXELS) + pixelY_t'(dy);

endmodule

/* source/renderController.sv */
`include "board_defines.svh"

module renderController
    import boardPkg::*,
           renderPkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         trigger,
    input  tileCoord_t   redX,
    input  tileCoord_t   redY,
    input  tileCoord_t   blueX,
    input  tileCoord_t   blueY,
    output logic         writeEnable,
    output tileAddress_u writeAddress,
    output colour_t      writeColour,
    output logic         scanStart,
    input  logic         scanDone,
    output logic         busy
);

    renderState_t state;
    renderState_t nextState;
    tileAddress_u clearCount;  // sweep position after reset
    tileAddress_u redAddress;
    tileAddress_u blueAddress;
    tileAddress_u redTile;     // positions taken at trigger
    tileAddress_u blueTile;
    logic         accept;
    logic         collision;

    // player positions to tile addresses, y selects the row
    always_comb begin
        redAddress.field.row     = redY;
        redAddress.field.column  = redX;
        blueAddress.field.row    = blueY;
        blueAddress.field.column = blueX;
    end

    assign accept    = (state == Idle) && trigger;
    assign collision = redTile.index == blueTile.index;

    always_ff @(posedge clock) begin
        if (accept) begin
            redTile  <= redAddress;
            blueTile <= blueAddress;
        end
    end

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= Clear;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Clear: begin
                if (clearCount.index == 8'(`TILE_COUNT - 1)) begin
                    nextState = Idle;
                end
            end
            Idle: begin
                if (trigger) begin
                    nextState = WriteRed;
                end
            end
            WriteRed:  nextState = WriteBlue;
            WriteBlue: nextState = Scan;
            Scan: begin
                if (scanDone) begin
                    nextState = Idle;
                end
            end
            default:   nextState = Clear;
        endcase
    end

    // one tile per cycle during the sweep
    always_ff @(posedge clock) begin
        if (reset) begin
            clearCount <= '0;
        end else if (state == Clear) begin
            clearCount.index <= clearCount.index + 1'b1;
        end
    end

    ////////////////////////////////////////
    // memory writes
    ////////////////////////////////////////

    always_comb begin
        writeEnable  = 1'b0;
        writeAddress = clearCount;
        writeColour  = `COLOUR_EMPTY;
        case (state)
            Clear: writeEnable = 1'b1;
            WriteRed: begin
                writeEnable  = 1'b1;
                writeAddress = redTile;
                writeColour  = collision ? `COLOUR_BOTH : `COLOUR_RED;
            end
            WriteBlue: begin
                writeEnable  = 1'b1;
                writeAddress = blueTile;
                writeColour  = collision ? `COLOUR_BOTH : `COLOUR_BLUE;
            end
            default: ;
        endcase
    end

    // scanner fetches tile 0 in the first Scan cycle
    assign scanStart = state == WriteBlue;
    assign busy      = state != Idle;

endmodule

/* source/boardRenderer.sv */
module boardRenderer
    import boardPkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       trigger,
    input  tileCoord_t redX,
    input  tileCoord_t redY,
    input  tileCoord_t blueX,
    input  tileCoord_t blueY,
    output pixelX_t    x,
    output pixelY_t    y,
    output colour_t    colour,
    output logic       plotEnable,
    output logic       busy
);

    logic         writeEnable;
    tileAddress_u writeAddress;
    colour_t      writeColour;
    tileAddress_u readAddress;
    colour_t      tileColour;
    logic         scanStart;
    logic         scanDone;

    renderController controller (
        .clock        (clock),
        .reset        (reset),
        .trigger      (trigger),
        .redX         (redX),
        .redY         (redY),
        .blueX        (blueX),
        .blueY        (blueY),
        .writeEnable  (writeEnable),
        .writeAddress (writeAddress),
        .writeColour  (writeColour),
        .scanStart    (scanStart),
        .scanDone     (scanDone),
        .busy         (busy)
    );

    tileMemory memory (
        .clock        (clock),
        .writeEnable  (writeEnable),
        .writeAddress (writeAddress),
        .writeColour  (writeColour),
        .readAddress  (readAddress),
        .tileColour   (tileColour)
    );

    tileScanner scanner (
        .clock        (clock),
        .reset        (reset),
        .scanStart    (scanStart),
        .readAddress  (readAddress),
        .tileColour   (tileColour),
        .x            (x),
        .y            (y),
        .colour       (colour),
        .plotEnable   (plotEnable),
        .scanDone     (scanDone)
    );

endmodule

/* bench/boardRenderer_assert.sv */
`include "board_defines.svh"

module boardRendererChecker
    import boardPkg::*,
           renderPkg::*;
(
    input logic         clock,
    input logic         reset,
    input logic         trigger,
    input tileCoord_t   redX,
    input tileCoord_t   redY,
    input tileCoord_t   blueX,
    input tileCoord_t   blueY,
    input pixelX_t      x,
    input pixelY_t      y,
    input colour_t      colour,
    input logic         plotEnable,
    input logic         busy,
    input renderState_t state
);

    localparam int passPixels = `TILE_COUNT * `TILE_PIXELS * `TILE_PIXELS;
    localparam logic [3:0] lastOffset = 4'(`TILE_PIXELS - 1);

    colour_t    shadow [`TILE_COUNT];    // board as it should be
    logic [7:0] redTile;
    logic [7:0] blueTile;
    logic [7:0] tile;                    // tile of the next pixel
    logic [3:0] dx;
    logic [3:0] dy;
    logic       scanning;
    int         sinceReset;
    int         pixelCount;
    int         passCount;
    int         errorCount = 0;
    pixelX_t    expX;
    pixelY_t    expY;
    colour_t    expColour;

    assign redTile   = {redY, redX};     // row in the upper half
    assign blueTile  = {blueY, blueX};
    assign expX      = pixelX_t'(tile[3:0]) * pixelX_t'(`TILE_PIXELS) + pixelX_t'(dx);
    assign expY      = pixelY_t'(tile[7:4]) * pixelY_t'(`TILE_PIXELS) + pixelY_t'(dy);
    assign expColour = shadow[tile];

    ////////////////////////////////////////
    // shadow board and pixel tracking
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `TILE_COUNT; i++) begin
                shadow[i] <= `COLOUR_EMPTY;
            end
            scanning   <= 1'b0;
            sinceReset <= 0;
            passCount  <= 0;
        end else begin
            if (sinceReset <= `TILE_COUNT) begin
                sinceReset <= sinceReset + 1;
            end
            if (trigger && !busy) begin
                shadow[redTile]  <= (redTile == blueTile) ? `COLOUR_BOTH : `COLOUR_RED;
                shadow[blueTile] <= (redTile == blueTile) ? `COLOUR_BOTH : `COLOUR_BLUE;
                scanning   <= 1'b1;
                pixelCount <= 0;
                tile       <= '0;
                dx         <= '0;
                dy         <= '0;
            end else if (scanning && !busy) begin
                scanning  <= 1'b0;       // pass over
                passCount <= passCount + 1;
            end
            if (plotEnable) begin
                pixelCount <= pixelCount + 1;
                dx <= (dx == lastOffset) ? '0 : dx + 1'b1;
                if (dx == lastOffset) begin
                    dy <= (dy == lastOffset) ? '0 : dy + 1'b1;
                    if (dy == lastOffset) begin
                        tile <= tile + 1'b1;
                    end
                end
            end
        end
    end

    task automatic reportFailure(input string message);
        $error("%s", message);
        errorCount++;
    endtask

    ////////////////////////////////////////
    // properties
    ////////////////////////////////////////

    resetBusy: assert property (@(posedge clock) reset |=> busy && !plotEnable)
        else reportFailure("busy low or plotting right after reset");

    // busy through the clear sweep, low once it ends
    clearLength: assert property (@(posedge clock) disable iff (reset)
        sinceReset <= `TILE_COUNT |-> busy == (sinceReset < `TILE_COUNT))
        else reportFailure($sformatf("mismatch busy %h after %h clear cycles",
            $sampled(busy), $sampled(sinceReset)));

    plotInScan: assert property (@(posedge clock) disable iff (reset)
        plotEnable |-> busy && state == Scan)
        else reportFailure("plotEnable high outside a scan pass");

    pixelOrder: assert property (@(posedge clock) disable iff (reset)
        plotEnable |-> x == expX && y == expY)
        else reportFailure($sformatf("mismatch x %h y %h expected %h %h",
            $sampled(x), $sampled(y), $sampled(expX), $sampled(expY)));

    pixelColour: assert property (@(posedge clock) disable iff (reset)
        plotEnable |-> colour == expColour)
        else reportFailure($sformatf("mismatch colour %h expected %h",
            $sampled(colour), $sampled(expColour)));

    passLength: assert property (@(posedge clock) disable iff (reset)
        scanning && !busy |-> pixelCount == passPixels)
        else reportFailure($sformatf("mismatch pixelCount %h expected %h",
            $sampled(pixelCount), passPixels));

endmodule

bind boardRenderer boardRendererChecker rendererCheck (
    .*,
    .state (controller.state)
);

/* bench/boardRendererTb.sv */
module boardRendererTb
    import boardPkg::*;
();

    localparam int cycleLimit = 8 * 25856 + 2000;  // eight passes plus the clear

    logic       clock;
    logic       reset;
    logic       trigger;
    tileCoord_t redX;
    tileCoord_t redY;
    tileCoord_t blueX;
    tileCoord_t blueY;
    pixelX_t    x;
    pixelY_t    y;
    colour_t    colour;
    logic       plotEnable;
    logic       busy;

    logic [31:0] seed = 32'hb5bc;
    tileCoord_t  pos [4];               // red x, red y, blue x, blue y
    int          cycles = 0;
    int          passesExpected = 0;
    int          benchErrors = 0;
    int          errorsSeen = 0;
    int          passed = 0;
    int          failed = 0;

    boardRenderer uut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("timeout, the run went past %0d cycles", cycleLimit);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] value);
        logic [31:0] v;
        v = value ^ (value << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    // new player positions, optionally on different tiles
    task automatic drawPositions(input bit apart);
        seed = xorshift(seed);
        pos[0] = seed[3:0];
        pos[1] = seed[7:4];
        pos[2] = seed[11:8];
        pos[3] = seed[15:12];
        if (apart && pos[0] == pos[2] && pos[1] == pos[3]) begin
            pos[2] = pos[2] + 1'b1;
        end
    endtask

    task automatic waitIdle();
        while (busy) begin
            @(posedge clock);
            #1;
        end
    endtask

    ////////////////////////////////////////
    // one render pass
    ////////////////////////////////////////

    task automatic renderPass(input bit pokeWhileBusy);
        int waited;
        waited = 0;
        {redX, redY, blueX, blueY} = {pos[0], pos[1], pos[2], pos[3]};
        trigger = 1'b1;
        @(posedge clock);
        #1;
        trigger = 1'b0;
        redX = ~redX;                   // a later pulse carries a new tile
        while (busy) begin
            @(posedge clock);
            #1;
            waited++;
            trigger = pokeWhileBusy && waited == 500;
        end
        @(posedge clock);               // pass count settles an edge later
        #1;
        passesExpected++;
        assert (uut.rendererCheck.passCount == passesExpected)
            else begin
                $display("mismatch passCount %h expected %h",
                    uut.rendererCheck.passCount, passesExpected);
                benchErrors++;
            end
    endtask

    task automatic finishTest(input int number, input string name);
        int errors;
        errors = uut.rendererCheck.errorCount + benchErrors - errorsSeen;
        errorsSeen += errors;
        if (errors == 0) begin
            $display("test %0d %s: ok", number, name);
            passed++;
        end else begin
            $display("test %0d %s: %0d errors", number, name, errors);
            failed++;
        end
    endtask

    initial begin
        reset   = 1'b1;
        trigger = 1'b0;
        redX    = '0;
        redY    = '0;
        blueX   = '0;
        blueY   = '0;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        // pulse in the middle of the clear sweep, dropped
        repeat (100) @(posedge clock);
        #1;
        trigger = 1'b1;
        @(posedge clock);
        #1;
        trigger = 1'b0;
        waitIdle();
        drawPositions(1'b1);
        renderPass(1'b0);
        finishTest(1, "reset clear");

        drawPositions(1'b1);
        renderPass(1'b0);
        finishTest(2, "distinct tiles");

        drawPositions(1'b0);
        pos[2] = pos[0];
        pos[3] = pos[1];
        renderPass(1'b0);
        finishTest(3, "collision");

        drawPositions(1'b0);
        renderPass(1'b0);
        finishTest(4, "pass length");

        drawPositions(1'b1);
        renderPass(1'b1);
        finishTest(5, "trigger while busy");

        pos = '{pos[2], pos[3], pos[0], pos[1]};   // players swap tiles
        renderPass(1'b0);
        finishTest(6, "accumulated board");

        $display("%0d tests passed, %0d failed", passed, failed);
        if (failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+source
source/boardPkg.sv
source/renderPkg.sv
source/tileMemory.sv
source/tileScanner.sv
source/renderController.sv
source/boardRenderer.sv
bench/boardRenderer_assert.sv
bench/boardRendererTb.sv
